/* rv_exec.f */
hdl/rv_isa_pkg.sv
hdl/exec_ctrl_pkg.sv
hdl/exec_result_if.sv
hdl/reg_file.sv
hdl/int_alu.sv
hdl/branch_unit.sv
hdl/writeback_merge.sv
hdl/exec_unit.sv
sim/exec_checker.sv
sim/exec_monitor.sv
sim/exec_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute slice testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f rv_exec.f --top-module exec_unit_tb \
    -o exec_unit_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/exec_unit_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
    exit 0
fi
exit 1

/* sim/exec_unit_tb.sv */
// Testbench top for the execute slice, runs a fixed program from a table with random idle gaps
`timescale 1ns/1ps

module exec_unit_tb;
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    localparam int RESET_CYCLES = 10;

    // One program row with its hand-computed result
    typedef struct {
        string     name;
        op_class_e op_class;
        alu_op_e   alu_op;
        br_cond_e  br_cond;
        logic      use_imm;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        word_t     imm;
        word_t     pc;
        logic      no_gap;
        logic      exp_we;
        word_t     exp_value;
        logic      exp_redirect;
        word_t     exp_target;
    } row_t;

    logic      clk;
    logic      rst;
    logic      issue;
    op_class_e op_class;
    alu_op_e   alu_op;
    br_cond_e  br_cond;
    logic      use_imm;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    reg_idx_t  rd_idx;
    word_t     imm;
    word_t     pc;
    logic      done;
    logic      wb_we;
    reg_idx_t  wb_rd_idx;
    word_t     wb_value;
    logic      redirect;
    word_t     redirect_pc;

    row_t   table_q[$];
    integer seed;
    int     cycle_count = 0;
    int     cycle_limit;
    int     gap;
    // Expectations never matched by a done pulse
    int     pending;
    // Failures seen by the bound assertions
    int     assert_errors;

    exec_unit DUT (.*);

    exec_monitor mon (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic alu_row(input string name, input alu_op_e op, input logic ui,
                           input reg_idx_t a, input reg_idx_t b, input reg_idx_t d,
                           input word_t im, input logic ng, input word_t val);
        row_t r;
        r = '{name, OP_ALU, op, BR_EQ, ui, a, b, d, im, 32'h0, ng, 1'b1, val, 1'b0, 32'h0};
        table_q.push_back(r);
    endtask

    task automatic br_row(input string name, input br_cond_e c, input reg_idx_t a,
                          input reg_idx_t b, input logic taken);
        row_t r;
        // All branches sit at 0x1000 with offset 0x40
        r = '{name, OP_BRANCH, ALU_ADD, c, 1'b0, a, b, 5'd0, 32'h40, 32'h1000, 1'b0,
              1'b0, 32'h0, taken, 32'h1040};
        table_q.push_back(r);
    endtask

    task automatic build_table();
        row_t r;
        alu_row("li_x1", ALU_ADD, 1, 0, 0, 1, 32'h5, 0, 32'h5);
        alu_row("li_x2", ALU_ADD, 1, 0, 0, 2, 32'hFFFF_FFF0, 0, 32'hFFFF_FFF0);
        alu_row("li_x3", ALU_ADD, 1, 0, 0, 3, 32'h3, 0, 32'h3);
        alu_row("add", ALU_ADD, 0, 1, 2, 4, 32'h0, 0, 32'hFFFF_FFF5);
        alu_row("sub", ALU_SUB, 0, 1, 3, 5, 32'h0, 0, 32'h2);
        alu_row("sll", ALU_SLL, 0, 1, 3, 6, 32'h0, 0, 32'h28);
        alu_row("slt_neg", ALU_SLT, 0, 2, 1, 7, 32'h0, 0, 32'h1);
        alu_row("sltu_neg", ALU_SLTU, 0, 2, 1, 8, 32'h0, 0, 32'h0);
        alu_row("xor", ALU_XOR, 0, 1, 3, 9, 32'h0, 0, 32'h6);
        alu_row("srl", ALU_SRL, 0, 2, 3, 10, 32'h0, 0, 32'h1FFF_FFFE);
        alu_row("sra_neg", ALU_SRA, 0, 2, 3, 11, 32'h0, 0, 32'hFFFF_FFFE);
        alu_row("or", ALU_OR, 0, 1, 2, 12, 32'h0, 0, 32'hFFFF_FFF5);
        alu_row("and", ALU_AND, 0, 1, 3, 13, 32'h0, 0, 32'h1);
        // Dependent chain reading each previous result through the bypass
        alu_row("chain_a", ALU_ADD, 1, 0, 0, 14, 32'h100, 0, 32'h100);
        alu_row("chain_b", ALU_ADD, 1, 14, 0, 14, 32'h1, 1, 32'h101);
        alu_row("chain_c", ALU_ADD, 0, 14, 14, 15, 32'h0, 1, 32'h202);
        // x0 write is reported but dropped
        alu_row("wr_x0", ALU_ADD, 1, 0, 0, 0, 32'h7F, 0, 32'h7F);
        alu_row("rd_x0", ALU_ADD, 0, 0, 1, 16, 32'h0, 1, 32'h5);
        br_row("beq_t", BR_EQ, 1, 1, 1);
        br_row("beq_n", BR_EQ, 1, 3, 0);
        br_row("bne_t", BR_NE, 1, 3, 1);
        br_row("bne_n", BR_NE, 1, 1, 0);
        br_row("blt_t", BR_LT, 2, 1, 1);
        br_row("blt_n", BR_LT, 1, 2, 0);
        br_row("bge_t", BR_GE, 1, 2, 1);
        br_row("bge_n", BR_GE, 2, 1, 0);
        br_row("bltu_t", BR_LTU, 1, 2, 1);
        br_row("bltu_n", BR_LTU, 2, 1, 0);
        br_row("bgeu_t", BR_GEU, 2, 1, 1);
        br_row("bgeu_n", BR_GEU, 1, 2, 0);
        // Backward JAL with the link at pc + 4
        r = '{"jal", OP_JAL, ALU_ADD, BR_EQ, 1'b0, 5'd0, 5'd0, 5'd17, 32'hFFFF_FF00,
              32'h2000, 1'b0, 1'b1, 32'h2004, 1'b1, 32'h1F00};
        table_q.push_back(r);
        alu_row("jal_use", ALU_ADD, 0, 17, 0, 18, 32'h0, 1, 32'h2004);
    endtask

    task automatic drive_idle();
        issue = 1'b0;
    endtask

    task automatic drive_row(input row_t r);
        issue = 1'b1;
        op_class = r.op_class;
        alu_op = r.alu_op;
        br_cond = r.br_cond;
        use_imm = r.use_imm;
        rs1_idx = r.rs1;
        rs2_idx = r.rs2;
        rd_idx = r.rd;
        imm = r.imm;
        pc = r.pc;
        mon.push_expect(r.name, r.exp_we, r.rd, r.exp_value, r.exp_redirect, r.exp_target);
    endtask

    // Run limit scales with the program length
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, program did not complete", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        issue = 1'b0;
        op_class = OP_ALU;
        alu_op = ALU_ADD;
        br_cond = BR_EQ;
        use_imm = 1'b0;
        rs1_idx = '0;
        rs2_idx = '0;
        rd_idx = '0;
        imm = '0;
        pc = '0;
        seed = 78;
        build_table();
        cycle_limit = RESET_CYCLES + 3 * table_q.size() + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        foreach (table_q[i]) begin
            gap = table_q[i].no_gap ? 0 : int'($unsigned($random(seed)) % 3);
            repeat (gap) begin
                @(posedge clk);
                #1 drive_idle();
            end
            @(posedge clk);
            #1 drive_row(table_q[i]);
        end
        @(posedge clk);
        #1 drive_idle();
        // Drain the last writeback and watch a few idle cycles
        repeat (4) @(posedge clk);
        pending = mon.pending_count();
        if (pending != 0) begin
            $display("Expectations left without a done pulse: %0d", pending);
        end
        assert_errors = DUT.u_writeback_merge.u_exec_checker.assert_errors;
        $display("Value errors: %0d, protocol errors: %0d, assertion errors: %0d",
                 mon.value_errors, mon.protocol_errors + pending, assert_errors);
        if (mon.value_errors == 0 && mon.protocol_errors + pending == 0
            && assert_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* sim/exec_monitor.sv */
// Testbench checker that pairs each done pulse with a queued expectation and compares results
`timescale 1ns/1ps

module exec_monitor (
    input logic                 clk,
    input logic                 rst,
    input logic                 issue,
    input logic                 done,
    input logic                 wb_we,
    input rv_isa_pkg::reg_idx_t wb_rd_idx,
    input rv_isa_pkg::word_t    wb_value,
    input logic                 redirect,
    input rv_isa_pkg::word_t    redirect_pc
);
    import rv_isa_pkg::*;

    // One expected writeback, queued by the testbench at issue time
    typedef struct {
        string    name;
        logic     we;
        reg_idx_t rd;
        word_t    value;
        logic     redirect;
        word_t    target;
    } expect_t;

    expect_t expect_q[$];
    int      value_errors = 0;
    int      protocol_errors = 0;
    // Set when the previous edge accepted an operation
    logic    done_due = 1'b0;

    task automatic push_expect(input string name, input logic we, input reg_idx_t rd,
                               input word_t value, input logic redir, input word_t target);
        expect_t e;
        e.name = name;
        e.we = we;
        e.rd = rd;
        e.value = value;
        e.redirect = redir;
        e.target = target;
        expect_q.push_back(e);
    endtask

    function automatic int pending_count();
        return expect_q.size();
    endfunction

    task automatic check_field(input string name, input string field,
                               input word_t exp_v, input word_t act_v);
        if (exp_v !== act_v) begin
            $display("FAILED %s %s expected %h actual %h", name, field, exp_v, act_v);
            value_errors++;
        end
    endtask

    // Inputs are stable at the edge, driven 1 ns later
    always @(posedge clk) begin
        done_due <= issue && !rst;
    end

    // Outputs sampled mid-cycle, away from the register updates
    always @(negedge clk) begin
        expect_t e;
        if (done && !done_due) begin
            $display("Unexpected done pulse at time %0t", $time);
            protocol_errors++;
        end else if (!done && done_due) begin
            $display("Missing done pulse for an issued operation at time %0t", $time);
            protocol_errors++;
            if (expect_q.size() > 0) void'(expect_q.pop_front());
        end else if (done) begin
            if (expect_q.size() == 0) begin
                $display("Done pulse with no queued expectation at time %0t", $time);
                protocol_errors++;
            end else begin
                e = expect_q.pop_front();
                check_field(e.name, "wb_we", word_t'(e.we), word_t'(wb_we));
                check_field(e.name, "redirect", word_t'(e.redirect), word_t'(redirect));
                // Payload only matters next to its strobe
                if (e.we) begin
                    check_field(e.name, "wb_rd_idx", word_t'(e.rd), word_t'(wb_rd_idx));
                    check_field(e.name, "wb_value", e.value, wb_value);
                end
                if (e.redirect) begin
                    check_field(e.name, "redirect_pc", e.target, redirect_pc);
                end
            end
        end
    end

endmodule

/* sim/exec_checker.sv */
// Protocol assertions on the writeback merge strobes, bound in from the testbench
`timescale 1ns/1ps

module exec_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     issue,
    input exec_ctrl_pkg::op_class_e op_class,
    input logic                     done,
    input logic                     wb_we,
    input logic                     redirect
);
    import exec_ctrl_pkg::*;

    // Count of failed assertions
    int assert_errors = 0;

    // Strobes cleared by the synchronous reset
    a_reset_quiet: assert property (@(posedge clk) rst |=> (!done && !wb_we && !redirect))
        else begin
            assert_errors++;
            $error("strobe high after a reset cycle");
        end

    a_we_done: assert property (@(posedge clk) wb_we |-> done)
        else begin
            assert_errors++;
            $error("wb_we without done");
        end

    a_redirect_done: assert property (@(posedge clk) redirect |-> done)
        else begin
            assert_errors++;
            $error("redirect without done");
        end

    // ALU operations never change the PC
    a_alu_no_redirect: assert property (@(posedge clk)
        (issue && !rst && op_class == OP_ALU) |=> !redirect)
        else begin
            assert_errors++;
            $error("redirect after an ALU operation");
        end

endmodule

bind writeback_merge exec_checker u_exec_checker (
    .clk      (clk),
    .rst      (rst),
    .issue    (issue),
    .op_class (op_class),
    .done     (done),
    .wb_we    (wb_we),
    .redirect (redirect)
);

/* hdl/exec_unit.sv */
// Execute and writeback top level joining register file, ALU, branch unit and merge
`timescale 1ns/1ps

module exec_unit (
    input  logic                      clk,
    input  logic                      rst,

    // Issue side, one operation per cycle
    input  logic                      issue,
    input  exec_ctrl_pkg::op_class_e  op_class,
    input  exec_ctrl_pkg::alu_op_e    alu_op,
    input  exec_ctrl_pkg::br_cond_e   br_cond,
    input  logic                      use_imm,
    input  rv_isa_pkg::reg_idx_t      rs1_idx,
    input  rv_isa_pkg::reg_idx_t      rs2_idx,
    input  rv_isa_pkg::reg_idx_t      rd_idx,
    input  rv_isa_pkg::word_t         imm,
    input  rv_isa_pkg::word_t         pc,

    // Result side, one cycle after issue
    output logic                      done,
    output logic                      wb_we,
    output rv_isa_pkg::reg_idx_t      wb_rd_idx,
    output rv_isa_pkg::word_t         wb_value,
    output logic                      redirect,
    output rv_isa_pkg::word_t         redirect_pc
);
    import rv_isa_pkg::*;

    // Source operands after bypass
    word_t rs1_val;
    word_t rs2_val;

    // Same-cycle unit results
    exec_result_if res_if ();

    // Write port fed back from the writeback register
    reg_file u_reg_file (
        .clk     (clk),
        .rd_idx  (wb_rd_idx),
        .rd_val  (wb_value),
        .rd_we   (wb_we),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    int_alu u_int_alu (
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .imm     (imm),
        .use_imm (use_imm),
        .alu_op  (alu_op),
        .res     (res_if)
    );

    branch_unit u_branch_unit (
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .imm      (imm),
        .pc       (pc),
        .op_class (op_class),
        .br_cond  (br_cond),
        .res      (res_if)
    );

    writeback_merge u_writeback_merge (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .op_class    (op_class),
        .rd_idx      (rd_idx),
        .res         (res_if),
        .done        (done),
        .wb_we       (wb_we),
        .wb_rd_idx   (wb_rd_idx),
        .wb_value    (wb_value),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

/* hdl/writeback_merge.sv */
// Merges ALU and branch results and registers the writeback and redirect one cycle after issue
`timescale 1ns/1ps

module writeback_merge (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue,
    input  exec_ctrl_pkg::op_class_e  op_class,
    input  rv_isa_pkg::reg_idx_t      rd_idx,
    exec_result_if.merge_dst          res,

    // Registered results, also the register file write port
    output logic                      done,
    output logic                      wb_we,
    output rv_isa_pkg::reg_idx_t      wb_rd_idx,
    output rv_isa_pkg::word_t         wb_value,
    output logic                      redirect,
    output rv_isa_pkg::word_t         redirect_pc
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    // Next-cycle strobes
    logic  we_nxt;
    logic  redirect_nxt;
    // Selected write value
    word_t value_nxt;

    // ALU and JAL write back, branches never do
    assign we_nxt = issue && ((op_class == OP_ALU) || (op_class == OP_JAL));

    // Link for JAL, ALU result otherwise
    assign value_nxt = res.link_valid ? res.br_link : res.alu_result;

    // Branch unit only flags taken for BRANCH and JAL
    assign redirect_nxt = issue && res.br_taken;

    // Strobes, single-cycle pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            done     <= 1'b0;
            wb_we    <= 1'b0;
            redirect <= 1'b0;
        end else begin
            done     <= issue;
            wb_we    <= we_nxt;
            redirect <= redirect_nxt;
        end
    end

    // Payload, only meaningful alongside the strobes
    always_ff @(posedge clk) begin
        wb_rd_idx   <= rd_idx;
        wb_value    <= value_nxt;
        redirect_pc <= res.br_target;
    end

endmodule

/* hdl/branch_unit.sv */
// Combinational branch evaluation with target and link computation for BRANCH and JAL
`timescale 1ns/1ps

module branch_unit (
    input  rv_isa_pkg::word_t         rs1_val,
    input  rv_isa_pkg::word_t         rs2_val,
    input  rv_isa_pkg::word_t         imm,
    input  rv_isa_pkg::word_t         pc,
    input  exec_ctrl_pkg::op_class_e  op_class,
    input  exec_ctrl_pkg::br_cond_e   br_cond,
    exec_result_if.branch_src         res
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    // Raw comparisons of the two sources
    logic eq;
    logic lt_s;
    logic lt_u;
    // Condition result for conditional branches
    logic cond_met;

    assign eq = rs1_val == rs2_val;
    assign lt_s = $signed(rs1_val) < $signed(rs2_val);
    assign lt_u = rs1_val < rs2_val;

    always_comb begin
        case (br_cond)
            BR_EQ:   cond_met = eq;
            BR_NE:   cond_met = !eq;
            BR_LT:   cond_met = lt_s;
            BR_GE:   cond_met = !lt_s;
            BR_LTU:  cond_met = lt_u;
            BR_GEU:  cond_met = !lt_u;
            // Reserved funct3 values never branch
            default: cond_met = 1'b0;
        endcase
    end

    // Taken only for branch classes
    always_comb begin
        case (op_class)
            OP_BRANCH: res.br_taken = cond_met;
            OP_JAL:    res.br_taken = 1'b1;
            default:   res.br_taken = 1'b0;
        endcase
    end

    // PC-relative target shared by branches and JAL
    assign res.br_target = pc + imm;

    // Return address for JAL
    assign res.br_link = pc + word_t'(LINK_OFFSET);
    assign res.link_valid = op_class == OP_JAL;

endmodule

/* hdl/int_alu.sv */
// Combinational integer ALU for register-register and register-immediate operations
`timescale 1ns/1ps

module int_alu (
    input  rv_isa_pkg::word_t       rs1_val,
    input  rv_isa_pkg::word_t       rs2_val,
    input  rv_isa_pkg::word_t       imm,
    input  logic                    use_imm,
    input  exec_ctrl_pkg::alu_op_e  alu_op,
    exec_result_if.alu_src          res
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    // Second operand after the immediate select
    word_t      op_b;
    // Shift amount from the low five bits
    logic [4:0] shamt;
    // Compare flags for the set-less-than forms
    logic       lt_signed;
    logic       lt_unsigned;

    assign op_b = use_imm ? imm : rs2_val;
    assign shamt = op_b[4:0];
    assign lt_signed = $signed(rs1_val) < $signed(op_b);
    assign lt_unsigned = rs1_val < op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  res.alu_result = rs1_val + op_b;
            ALU_SUB:  res.alu_result = rs1_val - op_b;
            ALU_SLL:  res.alu_result = rs1_val << shamt;
            // Set-less-than gives 0 or 1 in bit 0
            ALU_SLT:  res.alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: res.alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  res.alu_result = rs1_val ^ op_b;
            ALU_SRL:  res.alu_result = rs1_val >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  res.alu_result = word_t'($signed(rs1_val) >>> shamt);
            ALU_OR:   res.alu_result = rs1_val | op_b;
            ALU_AND:  res.alu_result = rs1_val & op_b;
            // Unused encodings
            default:  res.alu_result = '0;
        endcase
    end

endmodule

/* hdl/reg_file.sv */
// Integer register file with two async read ports, one write port and write-to-read bypass
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,

    // Write port, driven by the writeback register
    input  rv_isa_pkg::reg_idx_t rd_idx,
    input  rv_isa_pkg::word_t    rd_val,
    input  logic                rd_we,

    // Read ports
    input  rv_isa_pkg::reg_idx_t rs1_idx,
    input  rv_isa_pkg::reg_idx_t rs2_idx,
    output rv_isa_pkg::word_t    rs1_val,
    output rv_isa_pkg::word_t    rs2_val
);
    import rv_isa_pkg::*;

    // Storage for x1..x31 only
    // Unpacked so it maps onto LUT RAM with async read
    word_t regs [NUM_REGS-1:1];

    // Hit on the write in progress for each read port
    logic rs1_bypass;
    logic rs2_bypass;

    assign rs1_bypass = rd_we && (rd_idx == rs1_idx);
    assign rs2_bypass = rd_we && (rd_idx == rs2_idx);

    // Write, x0 never stored
    always_ff @(posedge clk) begin
        if (rd_we && (rd_idx != '0)) begin
            regs[rd_idx] <= rd_val;
        end
    end

    // rs1 read mux
    always_comb begin
        if (rs1_idx == '0) begin
            // x0 reads as zero
            rs1_val = '0;
        end else if (rs1_bypass) begin
            // Forward the value landing this cycle
            rs1_val = rd_val;
        end else begin
            rs1_val = regs[rs1_idx];
        end
    end

    // rs2 read mux, same structure
    always_comb begin
        if (rs2_idx == '0) begin
            rs2_val = '0;
        end else if (rs2_bypass) begin
            rs2_val = rd_val;
        end else begin
            rs2_val = regs[rs2_idx];
        end
    end

endmodule

/* hdl/exec_result_if.sv */
// Bundle of same-cycle ALU and branch results feeding the writeback merge
`timescale 1ns/1ps

interface exec_result_if;
    import rv_isa_pkg::*;

    // From the ALU
    word_t alu_result;

    // From the branch unit
    logic  br_taken;
    word_t br_target;
    word_t br_link;
    // High for JAL, selects the link as write value
    logic  link_valid;

    modport alu_src (
        output alu_result
    );

    modport branch_src (
        output br_taken,
        output br_target,
        output br_link,
        output link_valid
    );

    modport merge_dst (
        input alu_result,
        input br_taken,
        input br_target,
        input br_link,
        input link_valid
    );

endinterface

/* hdl/exec_ctrl_pkg.sv */
// Execute stage control encodings shared by the ALU, branch unit and writeback merge
package exec_ctrl_pkg;

    // Link increment for JAL, one instruction past the jump
    localparam int unsigned LINK_OFFSET = 4;

    // Which result retires for an issued operation
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_BRANCH = 2'd1,
        OP_JAL    = 2'd2
    } op_class_e;

    // ALU operations, shared by register and immediate forms
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Branch conditions, encoded as the RV32I funct3 field
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

endpackage

/* hdl/rv_isa_pkg.sv */
// Architectural widths and base types of RV32I, imported by every datapath block
package rv_isa_pkg;

    // Integer register width
    localparam int XLEN = 32;

    // Register index width and register count
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS = 32;

    // One data word
    typedef logic [XLEN-1:0] word_t;

    // Index into the integer register file
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage
